//--- flist.f
src/lsu_pkg.sv
src/lsu_addr_pipe.sv
src/lsu_pkt_pipe.sv
src/lsu_result_ctl.sv
src/lsu_lsc_ctl.sv
tb/lsu_lsc_ctl_assert.sv
tb/tb_lsu_lsc_ctl.sv

//--- tb/tb_lsu_lsc_ctl.sv
module tb_lsu_lsc_ctl;

   timeunit 1ns;
   timeprecision 1ps;

   import lsu_pkg::*;

   localparam int RESET_CYCLES   = 10;
   localparam int RUN_CYCLES     = 2000;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 90;   // Small margin

   typedef struct packed {
      logic     valid;
      logic     store;
      logic     unsign;
      size_t    size;
      addr_t    addr;
      addr_t    end_addr;
      logic     dccm;
      logic     pic;
      logic     mis;
      logic     fault;
      mscause_t cause;
   } acc_t;

   logic     clk = 1'b0;
   logic     rst;
   logic     lsu_valid_d, lsu_load_d, lsu_store_d, lsu_unsign_d;
   size_t    lsu_size_d;
   addr_t    rs1_d;
   offset_t  offset_d;
   logic     flush_m_up, flush_r;
   data_t    lsu_ld_data_m, bus_read_data_m;
   addr_t    lsu_addr_d, lsu_addr_m, lsu_addr_r, end_addr_r, exc_addr_r;
   logic     addr_in_dccm_m, addr_in_pic_m, addr_external_m, lsu_exc_m;
   data_t    lsu_result_m;
   logic     lsu_commit_r, exc_valid_r, exc_type_r, inst_type_r;
   mscause_t exc_mscause_r;

   acc_t        pipe [3];      // Expected D, M and R records
   logic [31:0] seed;
   int          cycles = 0;

   lsu_lsc_ctl i_lsu_lsc_ctl (.*);

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $fatal(1, "Simulation stopped by the cycle limit");
      end
   end

   // ************************************************************
   // Helpers
   // ************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      seed = xorshift32(seed);
      r    = seed;
   endtask

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
         $display(">>> FAIL");
         $fatal(1, "Output check failed");
      end
   endtask

   function automatic logic dccm_hit(input addr_t a);
      return (a >> DCCM_SIZE_LOG2) == (DCCM_BASE >> DCCM_SIZE_LOG2);
   endfunction

   function automatic logic pic_hit(input addr_t a);
      return (a >> PIC_SIZE_LOG2) == (PIC_BASE >> PIC_SIZE_LOG2);
   endfunction

   // ************************************************************
   // Reference model
   // ************************************************************
   function automatic acc_t predict(input logic v, input logic ld, input logic st,
                                    input logic us, input size_t sz, input addr_t rs1,
                                    input offset_t off);
      acc_t e;
      int   soff;
      logic unal, unmapped, straddle, ed, ep;
      soff       = $signed(off);
      e.valid    = v & (ld | st);
      e.store    = st;
      e.unsign   = us;
      e.size     = sz;
      e.addr     = rs1 + soff;
      e.end_addr = e.addr + ((sz == SZ_WORD) ? 3 : (sz == SZ_HALF) ? 1 : 0);
      unal       = (sz == SZ_WORD) ? (e.addr[1:0] != 2'b00) :
                   (sz == SZ_HALF) ? e.addr[0] : 1'b0;
      e.dccm     = dccm_hit(e.addr);
      e.pic      = pic_hit(e.addr);
      ed         = dccm_hit(e.end_addr);
      ep         = pic_hit(e.end_addr);
      unmapped   = (e.addr[31:28] == INTERNAL_REGION && !e.dccm && !e.pic) ||
                   (e.end_addr[31:28] == INTERNAL_REGION && !ed && !ep);
      straddle   = (e.dccm != ed) || (e.pic != ep);
      e.mis      = unal && !(e.dccm && ed);
      e.fault    = !e.mis && (unmapped || straddle);
      e.cause    = e.mis ? MSC_MISALIGNED : unmapped ? MSC_UNMAPPED :
                   straddle ? MSC_STRADDLE : MSC_NONE;
      return e;
   endfunction

   function automatic data_t extend(input data_t d, input size_t sz, input logic us);
      case (sz)
         SZ_BYTE: return us ? {24'b0, d[7:0]} : {{24{d[7]}}, d[7:0]};
         SZ_HALF: return us ? {16'b0, d[15:0]} : {{16{d[15]}}, d[15:0]};
         default: return d;
      endcase
   endfunction

   // ************************************************************
   // Stimulus and checks
   // ************************************************************
   task automatic drive_inputs();
      logic [31:0] r0, r1, r2, r3;
      next_rand(r0);
      next_rand(r1);
      next_rand(r2);
      next_rand(r3);
      lsu_valid_d  = (r0 % 10) < 7;
      lsu_store_d  = r0[4];
      lsu_load_d   = ~r0[4] & (r0[7:5] != 3'd0);   // Rarely neither
      lsu_size_d   = size_t'(r0[15:8] % 3);
      lsu_unsign_d = r0[16];
      flush_m_up   = (r0[21:18] == 4'd0);
      flush_r      = (r0[25:22] == 4'd0);
      case (r1[2:0])
         3'd0: rs1_d = DCCM_BASE + r2[15:0];
         3'd1: rs1_d = DCCM_BASE + 32'h1_0000 - 32'h10 + r2[4:0];   // Top edge
         3'd2: rs1_d = PIC_BASE + r2[14:0];
         3'd3: rs1_d = PIC_BASE + 32'h8000 - 32'h10 + r2[4:0];
         3'd4: rs1_d = PIC_BASE - 32'h10 + r2[4:0];
         3'd5: rs1_d = 32'hF000_0000 + r2[27:0];                  // Mostly unmapped
         3'd6: rs1_d = DCCM_BASE - 32'h10 + r2[4:0];
         default: rs1_d = {(r2[31:28] == 4'hF) ? 4'h1 : r2[31:28], r2[27:0]};
      endcase
      offset_d        = r1[31] ? r3[11:0] : {{8{r3[3]}}, r3[3:0]};
      lsu_ld_data_m   = r3;
      bus_read_data_m = r2 ^ r1;
   endtask

   task automatic check_outputs();
      acc_t  m;
      acc_t  r;
      data_t src;
      m = pipe[1];
      r = pipe[2];
      check_equal(lsu_addr_d, pipe[0].addr, "lsu_addr_d");
      if (m.valid) begin
         check_equal(lsu_addr_m, m.addr, "lsu_addr_m");
         check_equal(addr_in_dccm_m, m.dccm, "addr_in_dccm_m");
         check_equal(addr_in_pic_m, m.pic, "addr_in_pic_m");
         check_equal(addr_external_m, !m.dccm && !m.pic, "addr_external_m");
         check_equal(lsu_exc_m, m.mis || m.fault, "lsu_exc_m");
      end
      src = (m.dccm || m.pic) ? lsu_ld_data_m : bus_read_data_m;
      check_equal(lsu_result_m, m.valid ? extend(src, m.size, m.unsign) : '0, "lsu_result_m");
      check_equal(lsu_commit_r, r.valid && !flush_r, "lsu_commit_r");
      check_equal(exc_valid_r, r.valid && (r.mis || r.fault), "exc_valid_r");
      if (r.valid) begin
         check_equal(lsu_addr_r, r.addr, "lsu_addr_r");
         check_equal(end_addr_r, r.end_addr, "end_addr_r");
         check_equal(exc_addr_r, r.addr, "exc_addr_r");
      end
      if (r.valid && (r.mis || r.fault)) begin
         check_equal(exc_type_r, r.fault, "exc_type_r");
         check_equal(exc_mscause_r, r.cause, "exc_mscause_r");
         check_equal(inst_type_r, r.store, "inst_type_r");
      end
   endtask

   initial begin
      seed            = 32'h2bba;
      rst             = 1'b1;
      lsu_valid_d     = 1'b0;
      lsu_load_d      = 1'b0;
      lsu_store_d     = 1'b0;
      lsu_unsign_d    = 1'b0;
      lsu_size_d      = SZ_BYTE;
      rs1_d           = '0;
      offset_d        = '0;
      flush_m_up      = 1'b0;
      flush_r         = 1'b0;
      lsu_ld_data_m   = '0;
      bus_read_data_m = '0;
      for (int i = 0; i < 3; i++) pipe[i] = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      repeat (RUN_CYCLES) begin
         @(negedge clk);
         // Step the model across the edge that just passed
         pipe[2]       = pipe[1];
         pipe[2].valid = pipe[1].valid & ~flush_m_up;
         pipe[1]       = pipe[0];
         pipe[1].valid = pipe[0].valid & ~flush_m_up;
         drive_inputs();
         pipe[0] = predict(lsu_valid_d, lsu_load_d, lsu_store_d, lsu_unsign_d,
                           lsu_size_d, rs1_d, offset_d);
         #2;   // Let combinational outputs settle
         check_outputs();
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- tb/lsu_lsc_ctl_assert.sv
module lsu_lsc_ctl_assert (
   input  logic            clk,
   input  logic            rst,
   input  logic            addr_in_dccm_m,
   input  logic            addr_in_pic_m,
   input  logic            lsu_commit_r,
   input  logic            exc_valid_r,
   input  lsu_pkg::addr_t  exc_addr_r,
   input  lsu_pkg::addr_t  lsu_addr_r
);

   timeunit 1ns;
   timeprecision 1ps;

   // The two windows do not overlap
   region_onehot: assert property (@(posedge clk) disable iff (rst)
      !(addr_in_dccm_m && addr_in_pic_m))
      else $error("DCCM and PIC region flags are both set in M");

   // Nothing is in R right after a reset edge
   no_commit_after_rst: assert property (@(posedge clk) rst |=> !lsu_commit_r)
      else $error("Commit seen in the cycle after reset");

   exc_addr_match: assert property (@(posedge clk) disable iff (rst)
      exc_valid_r |-> (exc_addr_r == lsu_addr_r))
      else $error("Exception address differs from the R-stage address");

endmodule

bind lsu_lsc_ctl lsu_lsc_ctl_assert i_lsu_lsc_ctl_assert (.*);

//--- src/lsu_lsc_ctl.sv
module lsu_lsc_ctl (
   input  logic               clk,
   input  logic               rst,
   // D stage
   input  logic               lsu_valid_d,
   input  logic               lsu_load_d,
   input  logic               lsu_store_d,
   input  lsu_pkg::size_t     lsu_size_d,
   input  logic               lsu_unsign_d,
   input  lsu_pkg::addr_t     rs1_d,
   input  lsu_pkg::offset_t   offset_d,
   // Flushes and M-stage data
   input  logic               flush_m_up,
   input  logic               flush_r,
   input  lsu_pkg::data_t     lsu_ld_data_m,
   input  lsu_pkg::data_t     bus_read_data_m,
   // Address down the pipe
   output lsu_pkg::addr_t     lsu_addr_d,
   output lsu_pkg::addr_t     lsu_addr_m,
   output lsu_pkg::addr_t     lsu_addr_r,
   output lsu_pkg::addr_t     end_addr_r,
   output logic               addr_in_dccm_m,
   output logic               addr_in_pic_m,
   output logic               addr_external_m,
   output logic               lsu_exc_m,
   output lsu_pkg::data_t     lsu_result_m,
   output logic               lsu_commit_r,
   // Exception packet
   output logic               exc_valid_r,
   output logic               exc_type_r,
   output logic               inst_type_r,
   output lsu_pkg::mscause_t  exc_mscause_r,
   output lsu_pkg::addr_t     exc_addr_r
);

   import lsu_pkg::*;

   logic     misaligned_r, access_fault_r;
   mscause_t mscause_r;
   logic     valid_m, unsign_m, valid_r, store_r;
   size_t    size_m;

   lsu_addr_pipe i_lsu_addr_pipe (
      .clk, .rst, .rs1_d, .offset_d, .lsu_size_d,
      .lsu_addr_d, .lsu_addr_m, .addr_r(lsu_addr_r), .end_addr_r,
      .addr_in_dccm_m, .addr_in_pic_m, .addr_external_m, .lsu_exc_m,
      .misaligned_r, .access_fault_r, .mscause_r
   );

   lsu_pkt_pipe i_lsu_pkt_pipe (
      .clk, .rst, .lsu_valid_d, .lsu_load_d, .lsu_store_d, .lsu_unsign_d,
      .flush_m_up, .lsu_size_d,
      .valid_m, .store_m(), .unsign_m, .valid_r, .store_r, .size_m
   );

   lsu_result_ctl i_lsu_result_ctl (
      .valid_m, .unsign_m, .addr_external_m, .valid_r, .store_r,
      .misaligned_r, .access_fault_r, .flush_r, .size_m,
      .lsu_ld_data_m, .bus_read_data_m, .addr_r(lsu_addr_r), .mscause_r,
      .lsu_result_m, .lsu_commit_r, .exc_valid_r, .exc_type_r,
      .inst_type_r, .exc_mscause_r, .exc_addr_r
   );

endmodule

//--- src/lsu_result_ctl.sv
module lsu_result_ctl (
   input  logic               valid_m,
   input  logic               unsign_m,
   input  logic               addr_external_m,
   input  logic               valid_r,
   input  logic               store_r,
   input  logic               misaligned_r,
   input  logic               access_fault_r,
   input  logic               flush_r,
   input  lsu_pkg::size_t     size_m,
   input  lsu_pkg::data_t     lsu_ld_data_m,      // DCCM data
   input  lsu_pkg::data_t     bus_read_data_m,    // External bus data
   input  lsu_pkg::addr_t     addr_r,
   input  lsu_pkg::mscause_t  mscause_r,
   output lsu_pkg::data_t     lsu_result_m,
   output logic               lsu_commit_r,
   output logic               exc_valid_r,
   output logic               exc_type_r,
   output logic               inst_type_r,
   output lsu_pkg::mscause_t  exc_mscause_r,
   output lsu_pkg::addr_t     exc_addr_r
);

   import lsu_pkg::*;

   data_t ld_data_m;     // Selected source
   data_t ld_ext_m;      // After extension

   // ************************************************************
   // M-stage load result
   // ************************************************************
   assign ld_data_m = addr_external_m ? bus_read_data_m : lsu_ld_data_m;

   always_comb begin
      ld_ext_m = '0;
      case (size_m)
         SZ_BYTE: begin
            if (unsign_m) ld_ext_m = {24'b0, ld_data_m[7:0]};
            else          ld_ext_m = {{24{ld_data_m[7]}}, ld_data_m[7:0]};
         end
         SZ_HALF: begin
            if (unsign_m) ld_ext_m = {16'b0, ld_data_m[15:0]};
            else          ld_ext_m = {{16{ld_data_m[15]}}, ld_data_m[15:0]};
         end
         SZ_WORD: ld_ext_m = ld_data_m;
         default: ld_ext_m = '0;     // Unused size code
      endcase
   end

   // All zeros when nothing is in M
   assign lsu_result_m = valid_m ? ld_ext_m : '0;

   // ************************************************************
   // R-stage exception packet and commit
   // ************************************************************

   // Packet stays up under flush_r, only commit is blocked
   assign exc_valid_r   = valid_r & (misaligned_r | access_fault_r);
   assign exc_type_r    = access_fault_r;     // 0 is misaligned
   assign inst_type_r   = store_r;
   assign exc_mscause_r = mscause_r;
   assign exc_addr_r    = addr_r;

   assign lsu_commit_r = valid_r & ~flush_r;

endmodule

//--- src/lsu_pkt_pipe.sv
module lsu_pkt_pipe (
   input  logic             clk,
   input  logic             rst,
   input  logic             lsu_valid_d,
   input  logic             lsu_load_d,
   input  logic             lsu_store_d,
   input  logic             lsu_unsign_d,
   input  logic             flush_m_up,      // Kills D and M
   input  lsu_pkg::size_t   lsu_size_d,
   output logic             valid_m,
   output logic             store_m,
   output logic             unsign_m,
   output logic             valid_r,
   output logic             store_r,
   output lsu_pkg::size_t   size_m
);

   logic valid_d;      // Qualified D valid
   logic valid_m_in;
   logic valid_r_in;

   // ************************************************************
   // Valid chain
   // ************************************************************

   // Neither load nor store means no access at all
   assign valid_d = lsu_valid_d & (lsu_load_d | lsu_store_d);

   assign valid_m_in = valid_d & ~flush_m_up;
   assign valid_r_in = valid_m & ~flush_m_up;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_m <= 1'b0;
         valid_r <= 1'b0;
      end else begin
         valid_m <= valid_m_in;
         valid_r <= valid_r_in;
      end
   end

   // ************************************************************
   // Packet payload
   // ************************************************************

   // Only meaningful while the matching valid is set
   always_ff @(posedge clk) begin
      store_m  <= lsu_store_d;
      unsign_m <= lsu_unsign_d;
      size_m   <= lsu_size_d;
      store_r  <= store_m;     // Size and unsign are not needed past M
   end

endmodule

//--- src/lsu_addr_pipe.sv
module lsu_addr_pipe (
   input  logic               clk,
   input  logic               rst,
   input  lsu_pkg::addr_t     rs1_d,
   input  lsu_pkg::offset_t   offset_d,
   input  lsu_pkg::size_t     lsu_size_d,
   output lsu_pkg::addr_t     lsu_addr_d,
   output lsu_pkg::addr_t     lsu_addr_m,
   output lsu_pkg::addr_t     addr_r,
   output lsu_pkg::addr_t     end_addr_r,
   output logic               addr_in_dccm_m,
   output logic               addr_in_pic_m,
   output logic               addr_external_m,
   output logic               lsu_exc_m,
   output logic               misaligned_r,
   output logic               access_fault_r,
   output lsu_pkg::mscause_t  mscause_r
);

   import lsu_pkg::*;

   addr_t    end_addr_d, end_addr_m;
   addr_t    size_off_d;                        // Size minus one, in bytes
   logic     start_dccm_d, start_pic_d, end_dccm_d, end_pic_d;
   logic     unmapped_d, straddle_d, unaligned_d;
   logic     misaligned_d, access_fault_d;
   logic     misaligned_m, access_fault_m;
   mscause_t mscause_d, mscause_m;

   function automatic logic in_dccm(input addr_t a);
      return a[ADDR_W-1:DCCM_SIZE_LOG2] == DCCM_BASE[ADDR_W-1:DCCM_SIZE_LOG2];
   endfunction

   function automatic logic in_pic(input addr_t a);
      return a[ADDR_W-1:PIC_SIZE_LOG2] == PIC_BASE[ADDR_W-1:PIC_SIZE_LOG2];
   endfunction

   // ************************************************************
   // Address generation
   // ************************************************************
   assign lsu_addr_d = rs1_d + {{(ADDR_W-OFFSET_W){offset_d[OFFSET_W-1]}}, offset_d};

   always_comb begin
      size_off_d  = '0;
      unaligned_d = 1'b0;
      case (lsu_size_d)
         SZ_HALF: begin
            size_off_d  = addr_t'(1);
            unaligned_d = lsu_addr_d[0];
         end
         SZ_WORD: begin
            size_off_d  = addr_t'(3);
            unaligned_d = |lsu_addr_d[1:0];
         end
         default: ;                             // Byte access is always aligned
      endcase
   end

   assign end_addr_d = lsu_addr_d + size_off_d;

   // ************************************************************
   // Region decode and faults
   // ************************************************************
   assign start_dccm_d = in_dccm(lsu_addr_d);
   assign start_pic_d  = in_pic(lsu_addr_d);
   assign end_dccm_d   = in_dccm(end_addr_d);
   assign end_pic_d    = in_pic(end_addr_d);

   // Either end lands in the internal region outside both windows
   assign unmapped_d = ((lsu_addr_d[ADDR_W-1 -: 4] == INTERNAL_REGION) & ~start_dccm_d &
                        ~start_pic_d) |
                       ((end_addr_d[ADDR_W-1 -: 4] == INTERNAL_REGION) & ~end_dccm_d &
                        ~end_pic_d);
   assign straddle_d = (start_dccm_d ^ end_dccm_d) | (start_pic_d ^ end_pic_d);

   // DCCM takes unaligned accesses that stay inside it
   assign misaligned_d   = unaligned_d & ~(start_dccm_d & end_dccm_d);
   assign access_fault_d = (unmapped_d | straddle_d) & ~misaligned_d;

   assign mscause_d = misaligned_d ? MSC_MISALIGNED :
                      unmapped_d   ? MSC_UNMAPPED   :
                      straddle_d   ? MSC_STRADDLE   : MSC_NONE;

   // ************************************************************
   // D -> M -> R registers
   // ************************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         addr_in_dccm_m  <= 1'b0;
         addr_in_pic_m   <= 1'b0;
         addr_external_m <= 1'b0;
         misaligned_m    <= 1'b0;
         access_fault_m  <= 1'b0;
         mscause_m       <= MSC_NONE;
         misaligned_r    <= 1'b0;
         access_fault_r  <= 1'b0;
         mscause_r       <= MSC_NONE;
      end else begin
         addr_in_dccm_m  <= start_dccm_d;
         addr_in_pic_m   <= start_pic_d;
         addr_external_m <= ~start_dccm_d & ~start_pic_d;
         misaligned_m    <= misaligned_d;
         access_fault_m  <= access_fault_d;
         mscause_m       <= mscause_d;
         misaligned_r    <= misaligned_m;
         access_fault_r  <= access_fault_m;
         mscause_r       <= mscause_m;
      end
   end

   always_ff @(posedge clk) begin
      lsu_addr_m <= lsu_addr_d;
      end_addr_m <= end_addr_d;
      addr_r     <= lsu_addr_m;
      end_addr_r <= end_addr_m;
   end

   assign lsu_exc_m = misaligned_m | access_fault_m;

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

   // ************************************************************
   // Widths
   // ************************************************************
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int OFFSET_W   = 12;
   localparam int SIZE_W     = 2;
   localparam int MSCAUSE_W  = 4;

   typedef logic [ADDR_W-1:0]    addr_t;     // Byte address
   typedef logic [DATA_W-1:0]    data_t;     // Register or load data word
   typedef logic [OFFSET_W-1:0]  offset_t;   // Immediate, signed in use
   typedef logic [SIZE_W-1:0]    size_t;     // Access size code
   typedef logic [MSCAUSE_W-1:0] mscause_t;  // Fault cause

   // Access size codes
   localparam size_t SZ_BYTE = 2'd0;
   localparam size_t SZ_HALF = 2'd1;
   localparam size_t SZ_WORD = 2'd2;

   // ************************************************************
   // Memory map
   // ************************************************************
   localparam addr_t DCCM_BASE      = 32'hF004_0000;
   localparam int    DCCM_SIZE_LOG2 = 16;              // 64 KB window
   localparam addr_t PIC_BASE       = 32'hF00C_0000;
   localparam int    PIC_SIZE_LOG2  = 15;              // 32 KB window

   // Top nibble shared by the DCCM and PIC windows
   localparam logic [3:0] INTERNAL_REGION = 4'hF;

   // ************************************************************
   // Fault causes
   // ************************************************************
   localparam mscause_t MSC_NONE       = 4'd0;
   localparam mscause_t MSC_MISALIGNED = 4'd1;
   localparam mscause_t MSC_UNMAPPED   = 4'd2;   // Internal region, no window hit
   localparam mscause_t MSC_STRADDLE   = 4'd3;   // Start and end in different windows

endpackage
